// ==== cpri_iq_unpack.f ====
+incdir+common
common/unpack_pkg.sv
common/iq_stage_if.sv
rtl/lane_unpacker.sv
rtl/prb_expander.sv
rtl/fft_rescaler.sv
rtl/cpri_iq_unpack.sv
tests/tb_cpri_iq_unpack.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the unpacker testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f cpri_iq_unpack.f \
    --top-module tb_cpri_iq_unpack -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1

// ==== tests/tb_cpri_iq_unpack.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "unpack_settings.svh"

module tb_cpri_iq_unpack;
    import unpack_pkg::*;

    localparam int TOTAL_WORDS  = 2 * `RE_PER_SYMBOL * `WORDS_PER_GROUP / 8;
    localparam int STREAM_LIMIT = 10000;
    localparam int DRAIN_LIMIT  = 50;
    localparam int SMP_W        = 2 * `CPRS_W;

    typedef struct packed {
        iqs_t     i;
        iqs_t     q;
        re_addr_t addr;
        logic     last;
    } exp_entry_t;

    logic     i_clk;
    logic     i_reset;
    lanes_t   i_lane_data;
    logic     i_lane_vld;
    logic     o_lane_ready;
    logic     i_exp_wr;
    prb_t     i_exp_prb;
    exps_t    i_exp_data;
    shifts_t  i_fft_shift;
    logic     o_iq_vld;
    iqs_t     o_iq_i;
    iqs_t     o_iq_q;
    re_addr_t o_re_addr;
    logic     o_iq_last;

    // Reference model state
    logic [31:0] rng_state = 32'd57866;
    exps_t       exp_model [`PRB_PER_SYMBOL];
    shifts_t     shift_model;
    logic [`WORDS_PER_GROUP*`LANE_W-1:0] grp [`ANT_NUM];
    exp_entry_t  exp_q [$];
    int          word_idx = 0;
    int          model_re = 0;
    int          cycle_cnt = 0;
    logic        exp_ready = 1'b1;

    cpri_iq_unpack cpri_iq_unpack_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_lane_data  (i_lane_data),
        .i_lane_vld   (i_lane_vld),
        .o_lane_ready (o_lane_ready),
        .i_exp_wr     (i_exp_wr),
        .i_exp_prb    (i_exp_prb),
        .i_exp_data   (i_exp_data),
        .i_fft_shift  (i_fft_shift),
        .o_iq_vld     (o_iq_vld),
        .o_iq_i       (o_iq_i),
        .o_iq_q       (o_iq_q),
        .o_re_addr    (o_re_addr),
        .o_iq_last    (o_iq_last)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Signed 7-bit value times 2^exp, low 16 bits, then FFT gain
    function automatic iq_t expected_value(input logic [`CPRS_W-1:0] v, input exp_t e,
                                           input shift_t sh);
        int              val;
        logic [`IQ_W-1:0] scaled;
        iq_t             s;
        val = int'(v);
        if (v[`CPRS_W-1]) begin
            val = val - (1 << `CPRS_W);
        end
        scaled = `IQ_W'(val * (1 << e));
        s = iq_t'(scaled);
        return s >>> sh;
    endfunction

    // ----------------------------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_iq(input string name, input iq_t got, input iq_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input re_addr_t got, input re_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: o_re_addr got %0d expected %0d",
                                     $time, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    // Queue the expected RE for sample n of the current group
    task automatic push_sample(input int n);
        exp_entry_t          ent;
        logic [SMP_W-1:0]    smp;
        int                  prb;
        prb = model_re / `RE_PER_PRB;
        for (int a = 0; a < `ANT_NUM; a++) begin
            smp = grp[a][SMP_W*n +: SMP_W];
            ent.i[a] = expected_value(smp[SMP_W-1 -: `CPRS_W], exp_model[prb][a], shift_model[a]);
            ent.q[a] = expected_value(smp[`CPRS_W-1:0], exp_model[prb][a], shift_model[a]);
        end
        ent.addr = re_addr_t'(model_re);
        ent.last = (model_re == `RE_PER_SYMBOL - 1);
        exp_q.push_back(ent);
        model_re = (model_re == `RE_PER_SYMBOL - 1) ? 0 : model_re + 1;
    endtask

    // ----------------------------------------------------------
    // Monitor and model on pre-edge values
    // ----------------------------------------------------------
    always @(posedge i_clk) begin : monitor
        exp_entry_t ent;
        logic       accept;
        if (cycle_cnt > 0) begin
            check_flag("o_lane_ready", o_lane_ready, exp_ready);
            if (o_iq_vld === 1'b1) begin
                if (exp_q.size() == 0) begin
                    report_failure("output strobe seen while no sample was expected");
                end
                ent = exp_q.pop_front();
                for (int a = 0; a < `ANT_NUM; a++) begin
                    check_iq($sformatf("o_iq_i[%0d]", a), o_iq_i[a], ent.i[a]);
                    check_iq($sformatf("o_iq_q[%0d]", a), o_iq_q[a], ent.q[a]);
                end
                check_addr(o_re_addr, ent.addr);
                check_flag("o_iq_last", o_iq_last, ent.last);
            end else begin
                check_flag("o_iq_vld", o_iq_vld, 1'b0);
                check_flag("o_iq_last", o_iq_last, 1'b0);
            end
        end
        cycle_cnt++;

        accept = !i_reset && i_lane_vld && exp_ready;
        if (!exp_ready) begin
            exp_ready = 1'b1;
        end else if (accept) begin
            for (int a = 0; a < `ANT_NUM; a++) begin
                grp[a][`LANE_W*word_idx +: `LANE_W] = i_lane_data[a];
            end
            push_sample(word_idx);
            if (word_idx == `WORDS_PER_GROUP - 1) begin
                // Sample 7 flushes while ready is low
                push_sample(`WORDS_PER_GROUP);
                word_idx = 0;
                exp_ready = 1'b0;
            end else begin
                word_idx++;
            end
        end
    end

    initial begin
        exps_t ev;
        int    accepted;
        int    guard;
        i_reset     = 1'b1;
        i_lane_data = '0;
        i_lane_vld  = 1'b0;
        i_exp_wr    = 1'b0;
        i_exp_prb   = '0;
        i_exp_data  = '0;
        i_fft_shift = '0;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;

        // Neighboring PRBs always get a different exponent per antenna
        for (int p = 0; p < `PRB_PER_SYMBOL; p++) begin
            for (int a = 0; a < `ANT_NUM; a++) begin
                do begin
                    ev[a] = exp_t'(next_rand() % 32'd10);
                end while (p > 0 && ev[a] == exp_model[p-1][a]);
            end
            exp_model[p] = ev;
            @(posedge i_clk);
            i_exp_wr   <= 1'b1;
            i_exp_prb  <= prb_t'(p);
            i_exp_data <= ev;
        end
        for (int a = 0; a < `ANT_NUM; a++) begin
            shift_model[a] = shift_t'(next_rand() % 32'd8);
        end
        @(posedge i_clk);
        i_exp_wr    <= 1'b0;
        i_fft_shift <= shift_model;

        // ----------------------------------------------------------
        // Word stream for two symbols
        // ----------------------------------------------------------
        accepted = 0;
        guard = 0;
        while (accepted < TOTAL_WORDS) begin
            @(posedge i_clk);
            if (i_lane_vld && o_lane_ready) begin
                accepted++;
            end
            guard++;
            if (guard > STREAM_LIMIT) begin
                report_failure("timeout while streaming input words");
            end
            if (accepted < TOTAL_WORDS && (next_rand() % 32'd4) != 0) begin
                i_lane_vld  <= 1'b1;
                i_lane_data <= {next_rand(), next_rand()};
            end else begin
                i_lane_vld <= 1'b0;
            end
        end

        guard = 0;
        while (exp_q.size() != 0) begin
            @(negedge i_clk);
            guard++;
            if (guard > DRAIN_LIMIT) begin
                report_failure("timeout waiting for the remaining output samples");
            end
        end
        // Quiet period with no output strobe expected
        for (int k = 0; k < 20; k++) begin
            @(negedge i_clk);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/cpri_iq_unpack.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpri_iq_unpack (
    input  logic                   i_clk,
    input  logic                   i_reset,

    // Packed word stream
    input  unpack_pkg::lanes_t     i_lane_data,
    input  logic                   i_lane_vld,
    output logic                   o_lane_ready,

    // Exponent table writes, one PRB at a time
    input  logic                   i_exp_wr,
    input  unpack_pkg::prb_t       i_exp_prb,
    input  unpack_pkg::exps_t      i_exp_data,

    input  unpack_pkg::shifts_t    i_fft_shift,

    // Rescaled RE stream
    output logic                   o_iq_vld,
    output unpack_pkg::iqs_t       o_iq_i,
    output unpack_pkg::iqs_t       o_iq_q,
    output unpack_pkg::re_addr_t   o_re_addr,
    output logic                   o_iq_last
);
    import unpack_pkg::*;

    logic         smp_vld;
    packed_smps_t smp_data;

    iq_stage_if stage_if ();

    lane_unpacker lane_unpacker_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_lane_data  (i_lane_data),
        .i_lane_vld   (i_lane_vld),
        .o_lane_ready (o_lane_ready),
        .o_smp_vld    (smp_vld),
        .o_smp_data   (smp_data)
    );

    prb_expander prb_expander_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_smp_vld  (smp_vld),
        .i_smp_data (smp_data),
        .i_exp_wr   (i_exp_wr),
        .i_exp_prb  (i_exp_prb),
        .i_exp_data (i_exp_data),
        .o_stage    (stage_if.source)
    );

    fft_rescaler fft_rescaler_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_stage     (stage_if.sink),
        .i_fft_shift (i_fft_shift),
        .o_iq_vld    (o_iq_vld),
        .o_iq_i      (o_iq_i),
        .o_iq_q      (o_iq_q),
        .o_re_addr   (o_re_addr),
        .o_iq_last   (o_iq_last)
    );

endmodule

`default_nettype wire

// ==== rtl/fft_rescaler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "unpack_settings.svh"

module fft_rescaler (
    input  logic                       i_clk,
    input  logic                       i_reset,
    iq_stage_if.sink                   i_stage,
    input  unpack_pkg::shifts_t        i_fft_shift,
    output logic                       o_iq_vld,
    output unpack_pkg::iqs_t           o_iq_i,
    output unpack_pkg::iqs_t           o_iq_q,
    output unpack_pkg::re_addr_t       o_re_addr,
    output logic                       o_iq_last
);
    import unpack_pkg::*;

    // ----------------------------------------------------------
    // Strobes
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_iq_vld  <= 1'b0;
            o_iq_last <= 1'b0;
        end else begin
            o_iq_vld  <= i_stage.vld;
            o_iq_last <= i_stage.vld && i_stage.last;
        end
    end

    // ----------------------------------------------------------
    // FFT gain, arithmetic right shift per antenna
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_stage.vld) begin
            o_re_addr <= i_stage.re_addr;
            for (int a = 0; a < `ANT_NUM; a++) begin
                o_iq_i[a] <= $signed(i_stage.i_data[a]) >>> i_fft_shift[a];
                o_iq_q[a] <= $signed(i_stage.q_data[a]) >>> i_fft_shift[a];
            end
        end
    end

    // Last comes with a valid strobe on the final RE of the symbol
    a_last_vld : assert property (@(posedge i_clk) disable iff (i_reset)
        o_iq_last |-> o_iq_vld && o_re_addr == `RE_PER_SYMBOL - 1);

endmodule

`default_nettype wire

// ==== rtl/prb_expander.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "unpack_settings.svh"

module prb_expander (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_smp_vld,
    input  unpack_pkg::packed_smps_t   i_smp_data,
    input  logic                       i_exp_wr,
    input  unpack_pkg::prb_t           i_exp_prb,
    input  unpack_pkg::exps_t          i_exp_data,
    iq_stage_if.source                 o_stage
);
    import unpack_pkg::*;

    exps_t    exp_tab [`PRB_PER_SYMBOL];
    exps_t    cur_exp;
    logic [3:0] re_in_prb;
    prb_t     prb_cnt;
    re_addr_t re_cnt;

    // Sign extend, then scale up by the PRB exponent
    function automatic iq_t expand_bfp(input logic [`CPRS_W-1:0] v, input exp_t e);
        iq_t ext;
        ext = {{(`IQ_W - `CPRS_W){v[`CPRS_W-1]}}, v};
        return ext << e;
    endfunction

    // ----------------------------------------------------------
    // Exponent table
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_exp_wr) begin
            exp_tab[i_exp_prb] <= i_exp_data;
        end
    end

    assign cur_exp = exp_tab[prb_cnt];

    // ----------------------------------------------------------
    // RE and PRB counters
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_in_prb    <= '0;
            prb_cnt      <= '0;
            re_cnt       <= '0;
            o_stage.vld  <= 1'b0;
            o_stage.last <= 1'b0;
        end else begin
            o_stage.vld  <= i_smp_vld;
            o_stage.last <= i_smp_vld && (re_cnt == `RE_PER_SYMBOL - 1);
            if (i_smp_vld) begin
                if (re_in_prb == `RE_PER_PRB - 1) begin
                    re_in_prb <= '0;
                    prb_cnt   <= (prb_cnt == `PRB_PER_SYMBOL - 1) ? '0 : prb_cnt + 8'd1;
                end else begin
                    re_in_prb <= re_in_prb + 4'd1;
                end
                re_cnt <= (re_cnt == `RE_PER_SYMBOL - 1) ? '0 : re_cnt + 11'd1;
            end
        end
    end

    // Expansion, I from the upper half
    always_ff @(posedge i_clk) begin
        if (i_smp_vld) begin
            o_stage.re_addr <= re_cnt;
            for (int a = 0; a < `ANT_NUM; a++) begin
                o_stage.i_data[a] <= expand_bfp(i_smp_data[a][2*`CPRS_W-1 -: `CPRS_W], cur_exp[a]);
                o_stage.q_data[a] <= expand_bfp(i_smp_data[a][`CPRS_W-1:0], cur_exp[a]);
            end
        end
    end

    // Address in range and in step with the PRB counters
    a_re_addr : assert property (@(posedge i_clk) disable iff (i_reset)
        re_cnt < `RE_PER_SYMBOL && re_cnt == prb_cnt * `RE_PER_PRB + re_in_prb);

endmodule

`default_nettype wire

// ==== rtl/lane_unpacker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "unpack_settings.svh"

module lane_unpacker (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  unpack_pkg::lanes_t         i_lane_data,
    input  logic                       i_lane_vld,
    output logic                       o_lane_ready,
    output logic                       o_smp_vld,
    output unpack_pkg::packed_smps_t   o_smp_data
);
    import unpack_pkg::*;

    localparam int unsigned SMP_W      = 2 * `CPRS_W;
    // Bits each word runs ahead of the sample grid
    localparam int unsigned SPARE_W    = `LANE_W - SMP_W;
    localparam int unsigned SHIFT_BITS = $clog2(2 * `LANE_W);
    localparam int unsigned LAST_WORD  = `WORDS_PER_GROUP - 1;

    unpack_phase_e         phase;
    lanes_t                prev_word;
    logic                  accept;
    logic [SHIFT_BITS-1:0] win_shift;

    // Stall one cycle per group to flush sample 7
    assign o_lane_ready = (phase != PH7);
    assign accept       = i_lane_vld && o_lane_ready;

    // Offset of the sample inside {current, previous}
    // PH7 reads the previous word only
    assign win_shift = SHIFT_BITS'(`LANE_W - SPARE_W * phase);

    // ----------------------------------------------------------
    // Phase FSM
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase     <= PH0;
            o_smp_vld <= 1'b0;
        end else begin
            o_smp_vld <= accept || (phase == PH7);
            if (phase == PH7) begin
                phase <= PH0;
            end else if (accept) begin
                phase <= unpack_phase_e'(phase + 3'd1);
            end
        end
    end

    // ----------------------------------------------------------
    // Sample extraction
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (accept) begin
            prev_word <= i_lane_data;
        end
        if (accept || phase == PH7) begin
            for (int a = 0; a < `ANT_NUM; a++) begin
                o_smp_data[a] <= SMP_W'({i_lane_data[a], prev_word[a]} >> win_shift);
            end
        end
    end

    // Ready drops for one cycle after the seventh word of a group
    a_ready_gap : assert property (@(posedge i_clk) disable iff (i_reset)
        accept && phase == unpack_phase_e'(LAST_WORD) |=> !o_lane_ready ##1 o_lane_ready);

    // The flush cycle emits the top of word 6 and restarts the group
    for (genvar a = 0; a < `ANT_NUM; a++) begin : g_flush_chk
        a_ph7_flush : assert property (@(posedge i_clk) disable iff (i_reset)
            phase == PH7 |=> phase == PH0
                && o_smp_data[a] == prev_word[a][`LANE_W-1 -: SMP_W]);
    end

endmodule

`default_nettype wire

// ==== common/iq_stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Expanded samples from the expander to the rescaler
interface iq_stage_if;
    import unpack_pkg::*;

    logic     vld;
    iqs_t     i_data;
    iqs_t     q_data;
    re_addr_t re_addr;
    // High only with the last RE of a symbol
    logic     last;

    modport source (
        output vld,
        output i_data,
        output q_data,
        output re_addr,
        output last
    );

    modport sink (
        input  vld,
        input  i_data,
        input  q_data,
        input  re_addr,
        input  last
    );

endinterface

`default_nettype wire

// ==== common/unpack_pkg.sv ====
`default_nettype none

`include "unpack_settings.svh"

package unpack_pkg;

    // One antenna lane of an input word, lane 0 in the low bits
    typedef logic [`LANE_W-1:0]            lane_t;
    typedef lane_t [`ANT_NUM-1:0]          lanes_t;

    // Packed sample, I above Q
    typedef logic [2*`CPRS_W-1:0]          packed_smp_t;
    typedef packed_smp_t [`ANT_NUM-1:0]    packed_smps_t;

    // Expanded samples
    typedef logic signed [`IQ_W-1:0]       iq_t;
    typedef iq_t [`ANT_NUM-1:0]            iqs_t;

    typedef logic [`EXP_W-1:0]             exp_t;
    typedef exp_t [`ANT_NUM-1:0]           exps_t;
    typedef logic [`SHIFT_W-1:0]           shift_t;
    typedef shift_t [`ANT_NUM-1:0]         shifts_t;

    typedef logic [$clog2(`PRB_PER_SYMBOL)-1:0] prb_t;
    typedef logic [$clog2(`RE_PER_SYMBOL)-1:0]  re_addr_t;

    // Word position inside a packing group, PH7 is the flush cycle
    typedef enum logic [2:0] {PH0, PH1, PH2, PH3, PH4, PH5, PH6, PH7} unpack_phase_e;

endpackage

`default_nettype wire

// ==== common/unpack_settings.svh ====
`ifndef UNPACK_SETTINGS_SVH
`define UNPACK_SETTINGS_SVH

// ----------------------------------------------------------
// Link geometry
// ----------------------------------------------------------
`define ANT_NUM         4
`define LANE_W          16

// Block-float sample widths
`define CPRS_W          7
`define IQ_W            16
`define EXP_W           4
`define SHIFT_W         4

// Seven 16-bit words carry eight 14-bit samples per lane
`define WORDS_PER_GROUP 7

// ----------------------------------------------------------
// Symbol geometry
// ----------------------------------------------------------
`define RE_PER_PRB      12
`define PRB_PER_SYMBOL  132
`define RE_PER_SYMBOL   1584

`endif
